/* design/rdmaPkg.sv */
// Entry and field widths, opcode and FSM state types, reserved version constant
package rdmaPkg;

    // Work-queue entry, descriptor sits in the top WR_WIDTH bits
    localparam int ENTRY_WIDTH = 116;
    localparam int WR_WIDTH = 52;

    // Remote tokens
    localparam int ACK_WIDTH = 28;
    localparam int OFFLOAD_WIDTH = 8;

    // Header fields
    localparam int CONTROL_WIDTH = 16;
    localparam int PSN_WIDTH = 8;

    // Version bits at the top of every control field
    localparam logic [1:0] RSV_VERSION = 2'b00;

    // Header opcodes
    typedef enum logic [3:0] {
        OP_SEND = 4'd0,
        OP_REQ  = 4'd3,
        OP_ACK  = 4'd7
    } rdmaOpcodeE;

    // Scheduler states, each grant state lasts one cycle
    typedef enum logic [2:0] {
        S_IDLE          = 3'd0,
        S_GEN_REQ       = 3'd1,
        S_GEN_ACK       = 3'd2,
        S_GEN_SEND      = 3'd3,
        S_GEN_DMA_WRITE = 3'd4
    } opStateE;

endpackage

/* design/syncFifo.sv */
// Synchronous first-word fall-through FIFO with full, empty and fill count
`timescale 1ns/1ns

module syncFifo #(
    parameter int DEPTH = 16,
    parameter int WIDTH = 8
) (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    push,
    input  logic [WIDTH-1:0]        dataIn,
    input  logic                    pop,
    output logic [WIDTH-1:0]        dataOut,
    output logic                    full,
    output logic                    empty,
    output logic [$clog2(DEPTH):0]  count
);

    localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [WIDTH-1:0]       mem [DEPTH];
    logic [PTR_WIDTH-1:0]   wrPtr;
    logic [PTR_WIDTH-1:0]   rdPtr;
    logic [$clog2(DEPTH):0] nextCount;
    logic                   doPush;
    logic                   doPop;

    // Head entry is visible while not empty
    assign dataOut = mem[rdPtr];

    assign doPush = push && !full;
    assign doPop = pop && !empty;

    always_comb begin
        nextCount = count;
        if (doPush && !doPop) begin
            nextCount = count + 1'b1;
        end else if (doPop && !doPush) begin
            nextCount = count - 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (doPush) begin
            mem[wrPtr] <= dataIn;
        end
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
            full <= 1'b0;
            empty <= 1'b1;
        end else begin
            if (doPush) begin
                wrPtr <= (wrPtr == PTR_WIDTH'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= (rdPtr == PTR_WIDTH'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
            end
            count <= nextCount;
            full <= (nextCount == ($clog2(DEPTH) + 1)'(DEPTH));
            empty <= (nextCount == '0);
        end
    end

endmodule

/* design/rdmaOpScheduler.sv */
// Operation scheduler FSM: arbitration, FIFO strobes and header info
`timescale 1ns/1ns

module rdmaOpScheduler (
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                sqEmpty,
    input  logic                                rqEmpty,
    input  logic                                sqPreFull,
    input  logic                                rqPreFull,
    input  logic                                sqPreEmpty,
    input  logic                                rqPreEmpty,
    input  logic                                ackEmpty,
    input  logic                                offloadEmpty,
    input  logic                                sqDmaFull,
    input  logic                                rqDmaFull,
    input  logic [rdmaPkg::ENTRY_WIDTH-1:0]     sqData,
    input  logic [rdmaPkg::ENTRY_WIDTH-1:0]     rqData,
    input  logic [rdmaPkg::ENTRY_WIDTH-1:0]     sqPreData,
    output logic                                sqPop,
    output logic                                rqPop,
    output logic                                sqPrePush,
    output logic                                rqPrePush,
    output logic                                sqPrePop,
    output logic                                rqPrePop,
    output logic                                sqDmaPush,
    output logic                                rqDmaPush,
    output logic                                ackPop,
    output logic                                offloadPop,
    output logic                                infoValid,
    output logic [rdmaPkg::CONTROL_WIDTH-1:0]   rdmaControl,
    output logic [rdmaPkg::WR_WIDTH-1:0]        rdmaWr
);

    import rdmaPkg::*;

    opStateE    state;
    opStateE    nextState;
    rdmaOpcodeE opcode;
    logic       reqArb;
    logic       ackArb;
    logic       sendArb;
    logic       dmaWriteArb;

    // Only the scheduler drains the prefetch FIFOs and fills the DMA FIFOs,
    // so these stay true from the idle cycle into the grant cycle
    assign reqArb = !sqEmpty && !sqPreFull;
    assign ackArb = !rqEmpty && !rqPreFull;
    assign sendArb = !sqPreEmpty && !ackEmpty && !sqDmaFull;
    assign dmaWriteArb = !rqPreEmpty && !offloadEmpty && !rqDmaFull;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state <= S_IDLE;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = S_IDLE;
        if (state == S_IDLE) begin
            if (reqArb) begin
                nextState = S_GEN_REQ;
            end else if (ackArb) begin
                nextState = S_GEN_ACK;
            end else if (sendArb) begin
                nextState = S_GEN_SEND;
            end else if (dmaWriteArb) begin
                nextState = S_GEN_DMA_WRITE;
            end
        end
    end

    // Work queue entry moves to its prefetch FIFO
    assign sqPop = (state == S_GEN_REQ);
    assign sqPrePush = (state == S_GEN_REQ);
    assign rqPop = (state == S_GEN_ACK);
    assign rqPrePush = (state == S_GEN_ACK);

    // Token releases a parked entry into its DMA FIFO
    assign sqPrePop = (state == S_GEN_SEND);
    assign ackPop = (state == S_GEN_SEND);
    assign sqDmaPush = (state == S_GEN_SEND);
    assign rqPrePop = (state == S_GEN_DMA_WRITE);
    assign offloadPop = (state == S_GEN_DMA_WRITE);
    assign rqDmaPush = (state == S_GEN_DMA_WRITE);

    // DMA write produces no header
    assign infoValid = (state == S_GEN_REQ) || (state == S_GEN_ACK) || (state == S_GEN_SEND);

    always_comb begin
        case (state)
            S_GEN_REQ: begin
                opcode = OP_REQ;
                rdmaWr = sqData[ENTRY_WIDTH-1 -: WR_WIDTH];
            end
            S_GEN_ACK: begin
                opcode = OP_ACK;
                rdmaWr = rqData[ENTRY_WIDTH-1 -: WR_WIDTH];
            end
            default: begin
                opcode = OP_SEND;
                rdmaWr = sqPreData[ENTRY_WIDTH-1 -: WR_WIDTH];
            end
        endcase
    end

    // Version, two zero bits, opcode, then zero padding
    assign rdmaControl = {RSV_VERSION, 2'b00, opcode, {(CONTROL_WIDTH - 8){1'b0}}};

endmodule

/* design/rdmaOptr.sv */
// Operation generator: prefetch, DMA and token FIFOs around the scheduler
`timescale 1ns/1ns

module rdmaOptr #(
    parameter int PREFETCH_DEPTH = 16,
    parameter int DMA_DEPTH = 16,
    parameter int TOKEN_DEPTH = 4
) (
    input  logic                                clock,
    input  logic                                reset,
    input  logic [rdmaPkg::ENTRY_WIDTH-1:0]     sqData,
    input  logic [rdmaPkg::ENTRY_WIDTH-1:0]     rqData,
    input  logic                                sqEmpty,
    input  logic                                rqEmpty,
    output logic                                sqPop,
    output logic                                rqPop,
    input  logic                                ackPush,
    input  logic [rdmaPkg::ACK_WIDTH-1:0]       ackDataIn,
    output logic                                ackFull,
    input  logic                                offloadPush,
    input  logic [rdmaPkg::OFFLOAD_WIDTH-1:0]   offloadDataIn,
    output logic                                offloadFull,
    input  logic                                sqDmaPop,
    input  logic                                rqDmaPop,
    output logic [rdmaPkg::ENTRY_WIDTH-1:0]     sqDmaData,
    output logic [rdmaPkg::ENTRY_WIDTH-1:0]     rqDmaData,
    output logic                                sqDmaEmpty,
    output logic                                rqDmaEmpty,
    output logic                                infoValid,
    output logic [rdmaPkg::CONTROL_WIDTH-1:0]   rdmaControl,
    output logic [rdmaPkg::WR_WIDTH-1:0]        rdmaWr
);

    import rdmaPkg::*;

    logic [ENTRY_WIDTH-1:0] sqPreData;
    logic [ENTRY_WIDTH-1:0] rqPreData;
    logic sqPrePush;
    logic sqPrePop;
    logic sqPreFull;
    logic sqPreEmpty;
    logic rqPrePush;
    logic rqPrePop;
    logic rqPreFull;
    logic rqPreEmpty;
    logic sqDmaPush;
    logic sqDmaFull;
    logic rqDmaPush;
    logic rqDmaFull;
    logic ackPop;
    logic ackEmpty;
    logic offloadPop;
    logic offloadEmpty;

    // SQ entries wait here for an ack from the remote side
    syncFifo #(.DEPTH(PREFETCH_DEPTH), .WIDTH(ENTRY_WIDTH)) uSqPrefetch (
        .clock(clock), .reset(reset), .push(sqPrePush), .dataIn(sqData), .pop(sqPrePop),
        .dataOut(sqPreData), .full(sqPreFull), .empty(sqPreEmpty), .count()
    );

    // RQ entries wait for an offload header
    syncFifo #(.DEPTH(PREFETCH_DEPTH), .WIDTH(ENTRY_WIDTH)) uRqPrefetch (
        .clock(clock), .reset(reset), .push(rqPrePush), .dataIn(rqData), .pop(rqPrePop),
        .dataOut(rqPreData), .full(rqPreFull), .empty(rqPreEmpty), .count()
    );

    syncFifo #(.DEPTH(DMA_DEPTH), .WIDTH(ENTRY_WIDTH)) uSqDmaFifo (
        .clock(clock), .reset(reset), .push(sqDmaPush), .dataIn(sqPreData), .pop(sqDmaPop),
        .dataOut(sqDmaData), .full(sqDmaFull), .empty(sqDmaEmpty), .count()
    );

    syncFifo #(.DEPTH(DMA_DEPTH), .WIDTH(ENTRY_WIDTH)) uRqDmaFifo (
        .clock(clock), .reset(reset), .push(rqDmaPush), .dataIn(rqPreData), .pop(rqDmaPop),
        .dataOut(rqDmaData), .full(rqDmaFull), .empty(rqDmaEmpty), .count()
    );

    // Token contents are dropped, only their arrival counts
    syncFifo #(.DEPTH(TOKEN_DEPTH), .WIDTH(ACK_WIDTH)) uAckFifo (
        .clock(clock), .reset(reset), .push(ackPush), .dataIn(ackDataIn), .pop(ackPop),
        .dataOut(), .full(ackFull), .empty(ackEmpty), .count()
    );

    syncFifo #(.DEPTH(TOKEN_DEPTH), .WIDTH(OFFLOAD_WIDTH)) uOffloadFifo (
        .clock(clock), .reset(reset), .push(offloadPush), .dataIn(offloadDataIn),
        .pop(offloadPop), .dataOut(), .full(offloadFull), .empty(offloadEmpty), .count()
    );

    rdmaOpScheduler uScheduler (
        .clock(clock), .reset(reset),
        .sqEmpty(sqEmpty), .rqEmpty(rqEmpty),
        .sqPreFull(sqPreFull), .rqPreFull(rqPreFull),
        .sqPreEmpty(sqPreEmpty), .rqPreEmpty(rqPreEmpty),
        .ackEmpty(ackEmpty), .offloadEmpty(offloadEmpty),
        .sqDmaFull(sqDmaFull), .rqDmaFull(rqDmaFull),
        .sqData(sqData), .rqData(rqData), .sqPreData(sqPreData),
        .sqPop(sqPop), .rqPop(rqPop), .sqPrePush(sqPrePush), .rqPrePush(rqPrePush),
        .sqPrePop(sqPrePop), .rqPrePop(rqPrePop),
        .sqDmaPush(sqDmaPush), .rqDmaPush(rqDmaPush),
        .ackPop(ackPop), .offloadPop(offloadPop),
        .infoValid(infoValid), .rdmaControl(rdmaControl), .rdmaWr(rdmaWr)
    );

endmodule

/* design/headerGen.sv */
// Header register stage with a running packet sequence number
`timescale 1ns/1ns

module headerGen (
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                infoValid,
    input  logic [rdmaPkg::CONTROL_WIDTH-1:0]   rdmaControl,
    input  logic [rdmaPkg::WR_WIDTH-1:0]        rdmaWr,
    output logic                                headerValid,
    output logic [rdmaPkg::CONTROL_WIDTH-1:0]   headerControl,
    output logic [rdmaPkg::WR_WIDTH-1:0]        headerWr,
    output logic [rdmaPkg::PSN_WIDTH-1:0]       headerPsn
);

    import rdmaPkg::*;

    // PSN for the next header, wraps naturally
    logic [PSN_WIDTH-1:0] nextPsn;

    always_ff @(posedge clock) begin
        if (infoValid) begin
            headerControl <= rdmaControl;
            headerWr <= rdmaWr;
        end
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            headerValid <= 1'b0;
            headerPsn <= '0;
            nextPsn <= '0;
        end else begin
            headerValid <= infoValid;
            if (infoValid) begin
                headerPsn <= nextPsn;
                nextPsn <= nextPsn + 1'b1;
            end
        end
    end

endmodule

/* design/rdmaEngineTop.sv */
// Engine top level: SQ and RQ work queues, operation generator, header generator
`timescale 1ns/1ns

module rdmaEngineTop #(
    parameter int QUEUE_DEPTH = 16,
    parameter int TOKEN_DEPTH = 4
) (
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                sqPush,
    input  logic [rdmaPkg::ENTRY_WIDTH-1:0]     sqDataIn,
    output logic                                sqFull,
    input  logic                                rqPush,
    input  logic [rdmaPkg::ENTRY_WIDTH-1:0]     rqDataIn,
    output logic                                rqFull,
    input  logic                                ackPush,
    input  logic [rdmaPkg::ACK_WIDTH-1:0]       ackDataIn,
    output logic                                ackFull,
    input  logic                                offloadPush,
    input  logic [rdmaPkg::OFFLOAD_WIDTH-1:0]   offloadDataIn,
    output logic                                offloadFull,
    input  logic                                sqDmaPop,
    output logic [rdmaPkg::ENTRY_WIDTH-1:0]     sqDmaData,
    output logic                                sqDmaEmpty,
    input  logic                                rqDmaPop,
    output logic [rdmaPkg::ENTRY_WIDTH-1:0]     rqDmaData,
    output logic                                rqDmaEmpty,
    output logic                                headerValid,
    output logic [rdmaPkg::CONTROL_WIDTH-1:0]   headerControl,
    output logic [rdmaPkg::WR_WIDTH-1:0]        headerWr,
    output logic [rdmaPkg::PSN_WIDTH-1:0]       headerPsn
);

    import rdmaPkg::*;

    logic [ENTRY_WIDTH-1:0]     sqData;
    logic [ENTRY_WIDTH-1:0]     rqData;
    logic                       sqEmpty;
    logic                       rqEmpty;
    logic                       sqPop;
    logic                       rqPop;
    logic                       infoValid;
    logic [CONTROL_WIDTH-1:0]   rdmaControl;
    logic [WR_WIDTH-1:0]        rdmaWr;

    // Host-loaded work queues
    syncFifo #(.DEPTH(QUEUE_DEPTH), .WIDTH(ENTRY_WIDTH)) uSq (
        .clock(clock), .reset(reset), .push(sqPush), .dataIn(sqDataIn), .pop(sqPop),
        .dataOut(sqData), .full(sqFull), .empty(sqEmpty), .count()
    );

    syncFifo #(.DEPTH(QUEUE_DEPTH), .WIDTH(ENTRY_WIDTH)) uRq (
        .clock(clock), .reset(reset), .push(rqPush), .dataIn(rqDataIn), .pop(rqPop),
        .dataOut(rqData), .full(rqFull), .empty(rqEmpty), .count()
    );

    rdmaOptr #(
        .PREFETCH_DEPTH(QUEUE_DEPTH),
        .DMA_DEPTH(QUEUE_DEPTH),
        .TOKEN_DEPTH(TOKEN_DEPTH)
    ) uOptr (
        .clock(clock), .reset(reset),
        .sqData(sqData), .rqData(rqData), .sqEmpty(sqEmpty), .rqEmpty(rqEmpty),
        .sqPop(sqPop), .rqPop(rqPop),
        .ackPush(ackPush), .ackDataIn(ackDataIn), .ackFull(ackFull),
        .offloadPush(offloadPush), .offloadDataIn(offloadDataIn), .offloadFull(offloadFull),
        .sqDmaPop(sqDmaPop), .rqDmaPop(rqDmaPop),
        .sqDmaData(sqDmaData), .rqDmaData(rqDmaData),
        .sqDmaEmpty(sqDmaEmpty), .rqDmaEmpty(rqDmaEmpty),
        .infoValid(infoValid), .rdmaControl(rdmaControl), .rdmaWr(rdmaWr)
    );

    headerGen uHeaderGen (
        .clock(clock), .reset(reset),
        .infoValid(infoValid), .rdmaControl(rdmaControl), .rdmaWr(rdmaWr),
        .headerValid(headerValid), .headerControl(headerControl),
        .headerWr(headerWr), .headerPsn(headerPsn)
    );

endmodule

/* dv/rdmaEngine_assert.sv */
// Concurrent assertions on the scheduler's FIFO strobes and grant spacing
`timescale 1ns/1ns

module rdmaEngineAssert (
    input logic                 clock,
    input logic                 reset,
    input logic                 sqEmpty,
    input logic                 rqEmpty,
    input logic                 sqPreFull,
    input logic                 rqPreFull,
    input logic                 sqPreEmpty,
    input logic                 rqPreEmpty,
    input logic                 ackEmpty,
    input logic                 offloadEmpty,
    input logic                 sqDmaFull,
    input logic                 rqDmaFull,
    input logic                 sqPop,
    input logic                 rqPop,
    input logic                 sqPrePush,
    input logic                 rqPrePush,
    input logic                 sqPrePop,
    input logic                 rqPrePop,
    input logic                 sqDmaPush,
    input logic                 rqDmaPush,
    input logic                 ackPop,
    input logic                 offloadPop,
    input rdmaPkg::opStateE     state
);

    import rdmaPkg::*;

    logic popWhileEmpty;
    logic pushWhileFull;
    logic grant;

    assign popWhileEmpty = (sqPop && sqEmpty) || (rqPop && rqEmpty)
        || (sqPrePop && sqPreEmpty) || (rqPrePop && rqPreEmpty)
        || (ackPop && ackEmpty) || (offloadPop && offloadEmpty);

    assign pushWhileFull = (sqPrePush && sqPreFull) || (rqPrePush && rqPreFull)
        || (sqDmaPush && sqDmaFull) || (rqDmaPush && rqDmaFull);

    assign grant = (state != S_IDLE);

    noPopWhileEmpty: assert property (@(posedge clock) disable iff (!reset) !popWhileEmpty)
        else $error("scheduler popped an empty FIFO");

    noPushWhileFull: assert property (@(posedge clock) disable iff (!reset) !pushWhileFull)
        else $error("scheduler pushed into a full FIFO");

    // Every grant is followed by an idle cycle
    grantSpacing: assert property (@(posedge clock) disable iff (!reset) grant |=> !grant)
        else $error("two grant states in consecutive cycles");

endmodule

bind rdmaOpScheduler rdmaEngineAssert uSchedAssert (.*);

/* dv/rdmaEngineTb.sv */
// RDMA engine testbench with stimulus table, reference model, header and DMA monitors
`timescale 1ns/1ns

module rdmaEngineTb;

    import rdmaPkg::*;

    typedef enum logic [2:0] {
        ACT_PUSH_SQ,
        ACT_PUSH_RQ,
        ACT_PUSH_ACK,
        ACT_PUSH_OFFLOAD,
        ACT_DRAIN,
        ACT_STALL
    } actionE;

    typedef struct packed {
        actionE              act;
        logic [WR_WIDTH-1:0] desc;
    } rowT;

    typedef logic [ENTRY_WIDTH-1:0] wideT;

    localparam int WAIT_LIMIT = 1000;

    logic                       clock;
    logic                       reset;
    logic                       sqPush;
    logic [ENTRY_WIDTH-1:0]     sqDataIn;
    logic                       sqFull;
    logic                       rqPush;
    logic [ENTRY_WIDTH-1:0]     rqDataIn;
    logic                       rqFull;
    logic                       ackPush;
    logic [ACK_WIDTH-1:0]       ackDataIn;
    logic                       ackFull;
    logic                       offloadPush;
    logic [OFFLOAD_WIDTH-1:0]   offloadDataIn;
    logic                       offloadFull;
    logic                       sqDmaPop = 1'b0;
    logic [ENTRY_WIDTH-1:0]     sqDmaData;
    logic                       sqDmaEmpty;
    logic                       rqDmaPop = 1'b0;
    logic [ENTRY_WIDTH-1:0]     rqDmaData;
    logic                       rqDmaEmpty;
    logic                       headerValid;
    logic [CONTROL_WIDTH-1:0]   headerControl;
    logic [WR_WIDTH-1:0]        headerWr;
    logic [PSN_WIDTH-1:0]       headerPsn;

    rowT                    stimTable[$];
    // Reference model
    logic [WR_WIDTH-1:0]    expReq[$];
    logic [WR_WIDTH-1:0]    expAck[$];
    logic [WR_WIDTH-1:0]    expSend[$];
    logic [ENTRY_WIDTH-1:0] expSqDma[$];
    logic [ENTRY_WIDTH-1:0] expRqDma[$];
    // Entries still waiting for a token
    logic [ENTRY_WIDTH-1:0] sqAwait[$];
    logic [ENTRY_WIDTH-1:0] rqAwait[$];

    logic [PSN_WIDTH-1:0]   expPsn = '0;
    logic [31:0]            rngState = 32'h1214_209c;
    int                     headerCount = 0;
    int                     checkCount = 0;
    int                     errorCount = 0;

    rdmaEngineTop #(.QUEUE_DEPTH(16), .TOKEN_DEPTH(4)) UUT (
        .clock(clock), .reset(reset),
        .sqPush(sqPush), .sqDataIn(sqDataIn), .sqFull(sqFull),
        .rqPush(rqPush), .rqDataIn(rqDataIn), .rqFull(rqFull),
        .ackPush(ackPush), .ackDataIn(ackDataIn), .ackFull(ackFull),
        .offloadPush(offloadPush), .offloadDataIn(offloadDataIn), .offloadFull(offloadFull),
        .sqDmaPop(sqDmaPop), .sqDmaData(sqDmaData), .sqDmaEmpty(sqDmaEmpty),
        .rqDmaPop(rqDmaPop), .rqDmaData(rqDmaData), .rqDmaEmpty(rqDmaEmpty),
        .headerValid(headerValid), .headerControl(headerControl),
        .headerWr(headerWr), .headerPsn(headerPsn)
    );

    initial clock = 1'b0;
    always #4 clock = ~clock;

    task automatic checkValue(input string name, input wideT actual, input wideT expected);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("FAILED at time %0t: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic reportProblem(input string msg);
        errorCount++;
        $display("ERROR at time %0t: %s", $time, msg);
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function logic [31:0] nextRandom();
        rngState = xorshift32(rngState);
        return rngState;
    endfunction

    function logic [WR_WIDTH-1:0] randomDesc();
        logic [31:0] hi;
        hi = nextRandom();
        return {hi[19:0], nextRandom()};
    endfunction

    function automatic void addRow(input actionE act, input logic [WR_WIDTH-1:0] desc);
        rowT r;
        r.act = act;
        r.desc = desc;
        stimTable.push_back(r);
    endfunction

    function automatic int outstanding();
        return expReq.size() + expAck.size() + expSend.size() + expSqDma.size()
            + expRqDma.size();
    endfunction

    function automatic logic isBlocked(input actionE act);
        case (act)
            ACT_PUSH_SQ: return sqFull;
            ACT_PUSH_RQ: return rqFull;
            ACT_PUSH_ACK: return ackFull;
            default: return offloadFull;
        endcase
    endfunction

    task automatic buildTable();
        int i;
        for (i = 1; i <= 3; i++) begin
            addRow(ACT_PUSH_SQ, 52'hA_1000_0000_0000 | WR_WIDTH'(i));
        end
        for (i = 1; i <= 3; i++) begin
            addRow(ACT_PUSH_RQ, 52'hB_2000_0000_0000 | WR_WIDTH'(i));
        end
        addRow(ACT_DRAIN, '0);
        addRow(ACT_PUSH_ACK, 52'h0_0000_0AC0_0001);
        addRow(ACT_PUSH_ACK, 52'h0_0000_0AC0_0002);
        for (i = 0; i < 3; i++) begin
            addRow(ACT_PUSH_OFFLOAD, WR_WIDTH'(8'h40 + i));
        end
        addRow(ACT_DRAIN, '0);
        addRow(ACT_PUSH_ACK, 52'h0_0000_0AC0_0003);
        addRow(ACT_PUSH_SQ, 52'hA_1000_0000_0004);
        addRow(ACT_PUSH_RQ, 52'hB_2000_0000_0004);
        addRow(ACT_PUSH_ACK, 52'h0_0000_0AC0_0004);
        addRow(ACT_PUSH_OFFLOAD, 52'h0_0000_0000_0044);
        addRow(ACT_DRAIN, '0);
        // Back-pressure fills the SQ prefetch and then the SQ itself
        for (i = 0; i < 16; i++) begin
            addRow(ACT_PUSH_SQ, 52'hC_0000_0000_0000 | WR_WIDTH'(i));
        end
        addRow(ACT_DRAIN, '0);
        for (i = 0; i < 16; i++) begin
            addRow(ACT_PUSH_SQ, 52'hD_0000_0000_0000 | WR_WIDTH'(i));
        end
        addRow(ACT_STALL, '0);
        for (i = 0; i < 32; i++) begin
            addRow(ACT_PUSH_ACK, WR_WIDTH'(i));
            if (i == 15) begin
                addRow(ACT_DRAIN, '0);
            end
        end
        addRow(ACT_DRAIN, '0);
        // Mixed random traffic long enough to wrap the PSN
        for (i = 0; i < 96; i++) begin
            addRow(ACT_PUSH_SQ, randomDesc());
            addRow(ACT_PUSH_ACK, randomDesc());
            if (i % 4 == 0) begin
                addRow(ACT_PUSH_RQ, randomDesc());
                addRow(ACT_PUSH_OFFLOAD, randomDesc());
            end
        end
        addRow(ACT_DRAIN, '0);
    endtask

    task automatic pushOne(input rowT row);
        logic [ENTRY_WIDTH-1:0] entry;
        entry = {row.desc, nextRandom(), nextRandom()};
        case (row.act)
            ACT_PUSH_SQ: begin
                expReq.push_back(row.desc);
                sqAwait.push_back(entry);
                sqDataIn = entry;
                sqPush = 1'b1;
            end
            ACT_PUSH_RQ: begin
                expAck.push_back(row.desc);
                rqAwait.push_back(entry);
                rqDataIn = entry;
                rqPush = 1'b1;
            end
            ACT_PUSH_ACK: begin
                if (sqAwait.size() == 0) begin
                    reportProblem("ack token pushed with no SQ entry waiting for it");
                end else begin
                    entry = sqAwait.pop_front();
                    expSend.push_back(entry[ENTRY_WIDTH-1 -: WR_WIDTH]);
                    expSqDma.push_back(entry);
                end
                ackDataIn = row.desc[ACK_WIDTH-1:0];
                ackPush = 1'b1;
            end
            default: begin
                if (rqAwait.size() == 0) begin
                    reportProblem("offload token pushed with no RQ entry waiting for it");
                end else begin
                    expRqDma.push_back(rqAwait.pop_front());
                end
                offloadDataIn = row.desc[OFFLOAD_WIDTH-1:0];
                offloadPush = 1'b1;
            end
        endcase
        @(posedge clock);
        #1;
        sqPush = 1'b0;
        rqPush = 1'b0;
        ackPush = 1'b0;
        offloadPush = 1'b0;
    endtask

    task automatic applyRow(input rowT row);
        int waited;
        int startCount;
        waited = 0;
        case (row.act)
            ACT_DRAIN: begin
                while (outstanding() != 0 && waited < WAIT_LIMIT) begin
                    @(posedge clock);
                    #1;
                    waited++;
                end
                if (outstanding() != 0) begin
                    reportProblem($sformatf("drain timed out, %0d items still expected",
                        outstanding()));
                end
            end
            ACT_STALL: begin
                startCount = headerCount;
                while (!sqFull && waited < WAIT_LIMIT) begin
                    @(posedge clock);
                    #1;
                    waited++;
                end
                if (!sqFull) begin
                    reportProblem("timed out waiting for the SQ to report full");
                end
                repeat (16) @(posedge clock);
                #1;
                checkValue("headerCount while stalled", wideT'(headerCount), wideT'(startCount));
            end
            default: begin
                while (isBlocked(row.act) && waited < WAIT_LIMIT) begin
                    @(posedge clock);
                    #1;
                    waited++;
                end
                if (isBlocked(row.act)) begin
                    reportProblem($sformatf("timed out waiting for room to push, action %s",
                        row.act.name()));
                end else begin
                    pushOne(row);
                end
            end
        endcase
    endtask

    // Header fields are stable at the falling edge
    always @(negedge clock) begin
        if (reset && headerValid) begin
            headerCount++;
            checkValue("headerPsn", wideT'(headerPsn), wideT'(expPsn));
            expPsn = expPsn + 1'b1;
            checkValue("headerControl version", wideT'(headerControl[CONTROL_WIDTH-1 -: 4]),
                wideT'({RSV_VERSION, 2'b00}));
            case (headerControl[CONTROL_WIDTH-5 -: 4])
                OP_REQ: begin
                    if (expReq.size() == 0) begin
                        reportProblem("REQ header with no SQ entry outstanding");
                    end else begin
                        checkValue("headerWr of REQ", wideT'(headerWr), wideT'(expReq.pop_front()));
                    end
                end
                OP_ACK: begin
                    if (expAck.size() == 0) begin
                        reportProblem("ACK header with no RQ entry outstanding");
                    end else begin
                        checkValue("headerWr of ACK", wideT'(headerWr), wideT'(expAck.pop_front()));
                    end
                end
                OP_SEND: begin
                    if (expSend.size() == 0) begin
                        reportProblem("SEND header with no ack token outstanding");
                    end else begin
                        checkValue("headerWr of SEND", wideT'(headerWr),
                            wideT'(expSend.pop_front()));
                    end
                end
                default: begin
                    reportProblem($sformatf("header with unknown opcode %h",
                        headerControl[CONTROL_WIDTH-5 -: 4]));
                end
            endcase
        end
    end

    // DMA side pops whatever shows up and checks it
    always @(posedge clock) begin
        #1;
        sqDmaPop = 1'b0;
        rqDmaPop = 1'b0;
        if (reset && !sqDmaEmpty) begin
            if (expSqDma.size() == 0) begin
                reportProblem("SQ DMA entry appeared with no ack token outstanding");
            end else begin
                checkValue("sqDmaData", sqDmaData, expSqDma.pop_front());
            end
            sqDmaPop = 1'b1;
        end
        if (reset && !rqDmaEmpty) begin
            if (expRqDma.size() == 0) begin
                reportProblem("RQ DMA entry appeared with no offload token outstanding");
            end else begin
                checkValue("rqDmaData", rqDmaData, expRqDma.pop_front());
            end
            rqDmaPop = 1'b1;
        end
    end

    initial begin
        int i;
        reset = 1'b0;
        sqPush = 1'b0;
        sqDataIn = '0;
        rqPush = 1'b0;
        rqDataIn = '0;
        ackPush = 1'b0;
        ackDataIn = '0;
        offloadPush = 1'b0;
        offloadDataIn = '0;
        buildTable();
        repeat (2) @(posedge clock);
        #1;
        reset = 1'b1;
        checkValue("headerValid", wideT'(headerValid), wideT'(1'b0));
        checkValue("sqDmaEmpty", wideT'(sqDmaEmpty), wideT'(1'b1));
        checkValue("rqDmaEmpty", wideT'(rqDmaEmpty), wideT'(1'b1));
        checkValue("sqFull", wideT'(sqFull), wideT'(1'b0));
        checkValue("rqFull", wideT'(rqFull), wideT'(1'b0));
        checkValue("ackFull", wideT'(ackFull), wideT'(1'b0));
        checkValue("offloadFull", wideT'(offloadFull), wideT'(1'b0));
        for (i = 0; i < stimTable.size(); i++) begin
            applyRow(stimTable[i]);
        end
        checkValue("parked SQ entries", wideT'(sqAwait.size()), '0);
        checkValue("parked RQ entries", wideT'(rqAwait.size()), '0);
        $display("Checks: %0d, errors: %0d, headers: %0d", checkCount, errorCount, headerCount);
        if (errorCount == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* rdmaEngine.f */
design/rdmaPkg.sv
design/syncFifo.sv
design/rdmaOpScheduler.sv
design/rdmaOptr.sv
design/headerGen.sv
design/rdmaEngineTop.sv
dv/rdmaEngine_assert.sv
dv/rdmaEngineTb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = rdmaEngineTb
FILELIST  = rdmaEngine.f
OBJDIR    = obj_dir
PASS_TEXT = *** TEST PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_TEXT)"

clean:
	rm -rf $(OBJDIR)
